//--- logic/pcyn_defines.svh
`ifndef PCYN_DEFINES_SVH
`define PCYN_DEFINES_SVH

`define PCYN_DATA_WIDTH      32
`define PCYN_REG_COUNT       32
`define PCYN_ROB_DEPTH       16
`define PCYN_RS_DEPTH        8
`define PCYN_INSN_FIFO_DEPTH 4
`define PCYN_RESET_PC        32'h00000000

// RV32I major opcodes
`define PCYN_OPC_OP          7'b0110011
`define PCYN_OPC_OP_IMM      7'b0010011
`define PCYN_OPC_LUI         7'b0110111

// funct3 of the integer ALU group
`define PCYN_F3_ADD_SUB      3'b000
`define PCYN_F3_SLL          3'b001
`define PCYN_F3_SLT          3'b010
`define PCYN_F3_SLTU         3'b011
`define PCYN_F3_XOR          3'b100
`define PCYN_F3_SR           3'b101
`define PCYN_F3_OR           3'b110
`define PCYN_F3_AND          3'b111

// ADDI x0, x0, 0
`define PCYN_NOP             32'h00000013

`endif

//--- logic/pcyn_pkg.sv
`include "pcyn_defines.svh"

package pcyn_pkg;

    typedef logic [`PCYN_DATA_WIDTH-1:0] word_t;
    typedef logic [$clog2(`PCYN_REG_COUNT)-1:0] reg_idx_t;
    typedef logic [$clog2(`PCYN_ROB_DEPTH)-1:0] rob_tag_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

endpackage

//--- logic/pcyn_fetch.sv
`include "pcyn_defines.svh"

module pcyn_fetch import pcyn_pkg::*; #(
    parameter int FIFO_DEPTH = `PCYN_INSN_FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_ic_valid,
    input  word_t i_ic_insn,
    input  logic  i_decode_stall,
    output logic  o_ic_en,
    output word_t o_ic_pc,
    output logic  o_fetch_valid,
    output word_t o_fetch_pc,
    output word_t o_fetch_insn
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    word_t          pc_q;
    word_t          pc_mem [FIFO_DEPTH];
    word_t          insn_mem [FIFO_DEPTH];
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           run_q;
    logic           full;
    logic           push;
    logic           pop;

    // Extra pointer bit tells full from empty
    assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                  (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign o_ic_en       = run_q && !full;
    assign o_ic_pc       = pc_q;
    assign push          = o_ic_en && i_ic_valid;
    assign o_fetch_valid = (wr_ptr != rd_ptr);
    assign pop           = o_fetch_valid && !i_decode_stall;
    assign o_fetch_pc    = pc_mem[rd_ptr[PTR_W-1:0]];
    assign o_fetch_insn  = insn_mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q   <= `PCYN_RESET_PC;
            wr_ptr <= '0;
            rd_ptr <= '0;
            run_q  <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (push) begin
                pc_q   <= pc_q + 32'd4;
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr[PTR_W-1:0]]   <= pc_q;
            insn_mem[wr_ptr[PTR_W-1:0]] <= i_ic_insn;
        end
    end

endmodule

//--- logic/pcyn_decode.sv
`include "pcyn_defines.svh"

module pcyn_decode import pcyn_pkg::*; (
    input  logic     i_fetch_valid,
    input  word_t    i_fetch_pc,
    input  word_t    i_fetch_insn,
    input  logic     i_rob_stall,
    input  logic     i_rs_stall,
    input  logic     i_rat_rdy [2],
    input  word_t    i_rat_data [2],
    input  rob_tag_t i_rat_tag [2],
    input  logic     i_rob_lookup_rdy [2],
    input  word_t    i_rob_lookup_data [2],
    input  rob_tag_t i_rob_reserve_tag,
    output logic     o_decode_stall,
    output reg_idx_t o_rat_rsrc [2],
    output logic     o_rat_rename_en,
    output reg_idx_t o_rat_rename_rdst,
    output logic     o_rob_reserve_en,
    output reg_idx_t o_rob_rdst,
    output rob_tag_t o_rob_lookup_tag [2],
    output logic     o_rs_reserve_en,
    output alu_op_e  o_rs_op,
    output rob_tag_t o_rs_dst_tag,
    output logic     o_rs_src_rdy [2],
    output word_t    o_rs_src_data [2],
    output rob_tag_t o_rs_src_tag [2]
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    word_t      imm_i;
    word_t      imm_u;
    alu_op_e    f3_op;
    reg_idx_t   rdst;
    logic [1:0] use_rs;
    word_t      imm;
    logic       dispatch;

    assign opcode = i_fetch_insn[6:0];
    assign funct3 = i_fetch_insn[14:12];
    assign alt    = i_fetch_insn[30];
    assign imm_i  = {{20{i_fetch_insn[31]}}, i_fetch_insn[31:20]};
    assign imm_u  = {i_fetch_insn[31:12], 12'b0};

    assign o_rat_rsrc[0] = i_fetch_insn[19:15];
    assign o_rat_rsrc[1] = i_fetch_insn[24:20];

    always_comb begin
        case (funct3)
            `PCYN_F3_ADD_SUB: f3_op = (alt && opcode == `PCYN_OPC_OP) ? ALU_SUB : ALU_ADD;
            `PCYN_F3_SLL:     f3_op = ALU_SLL;
            `PCYN_F3_SLT:     f3_op = ALU_SLT;
            `PCYN_F3_SLTU:    f3_op = ALU_SLTU;
            `PCYN_F3_XOR:     f3_op = ALU_XOR;
            `PCYN_F3_SR:      f3_op = alt ? ALU_SRA : ALU_SRL;
            `PCYN_F3_OR:      f3_op = ALU_OR;
            `PCYN_F3_AND:     f3_op = ALU_AND;
            default:          f3_op = ALU_ADD;
        endcase
    end

    // Anything else becomes an ADD of zeros with no destination
    always_comb begin
        o_rs_op = ALU_ADD;
        rdst    = '0;
        use_rs  = 2'b00;
        imm     = '0;
        if (opcode == `PCYN_OPC_OP) begin
            o_rs_op = f3_op;
            rdst    = i_fetch_insn[11:7];
            use_rs  = 2'b11;
        end else if (opcode == `PCYN_OPC_OP_IMM) begin
            o_rs_op = f3_op;
            rdst    = i_fetch_insn[11:7];
            use_rs  = 2'b01;
            imm     = imm_i;
        end else if (opcode == `PCYN_OPC_LUI) begin
            rdst = i_fetch_insn[11:7];
            imm  = imm_u;
        end
    end

    // Register file first, then a finished ROB entry, else wait on the tag
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_rs_src_tag[s] = i_rat_tag[s];
            o_rs_src_rdy[s] = 1'b1;
            if (!use_rs[s]) begin
                o_rs_src_data[s] = (s == 1) ? imm : '0;
            end else if (i_rat_rdy[s]) begin
                o_rs_src_data[s] = i_rat_data[s];
            end else if (i_rob_lookup_rdy[s]) begin
                o_rs_src_data[s] = i_rob_lookup_data[s];
            end else begin
                o_rs_src_rdy[s]  = 1'b0;
                o_rs_src_data[s] = '0;
            end
        end
    end

    assign o_decode_stall    = i_rob_stall || i_rs_stall;
    assign dispatch          = i_fetch_valid && !o_decode_stall;
    assign o_rob_reserve_en  = dispatch;
    assign o_rs_reserve_en   = dispatch;
    assign o_rob_rdst        = rdst;
    assign o_rob_lookup_tag  = i_rat_tag;
    assign o_rat_rename_en   = dispatch && (rdst != '0);
    assign o_rat_rename_rdst = rdst;
    assign o_rs_dst_tag      = i_rob_reserve_tag;

endmodule

//--- logic/pcyn_rat.sv
`include "pcyn_defines.svh"

module pcyn_rat import pcyn_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  reg_idx_t i_rsrc [2],
    input  logic     i_rename_en,
    input  reg_idx_t i_rename_rdst,
    input  rob_tag_t i_rename_tag,
    input  logic     i_retire_en,
    input  reg_idx_t i_retire_rdst,
    input  word_t    i_retire_data,
    input  rob_tag_t i_retire_tag,
    output logic     o_rdy [2],
    output word_t    o_data [2],
    output rob_tag_t o_tag [2]
);

    localparam int REGS = `PCYN_REG_COUNT;

    word_t                regs [REGS];
    logic [REGS-1:0]      renamed;
    rob_tag_t             tags [REGS];

    // x0 reads as a ready zero
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_rdy[s]  = (i_rsrc[s] == '0) || !renamed[i_rsrc[s]];
            o_data[s] = (i_rsrc[s] == '0) ? '0 : regs[i_rsrc[s]];
            o_tag[s]  = tags[i_rsrc[s]];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            renamed <= '0;
            for (int r = 0; r < REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (i_retire_en && i_retire_rdst != '0) begin
                regs[i_retire_rdst] <= i_retire_data;
                if (tags[i_retire_rdst] == i_retire_tag) begin
                    renamed[i_retire_rdst] <= 1'b0;
                end
            end
            // Later assignment so a new rename beats the retire
            if (i_rename_en && i_rename_rdst != '0) begin
                renamed[i_rename_rdst] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rename_en && i_rename_rdst != '0) begin
            tags[i_rename_rdst] <= i_rename_tag;
        end
    end

endmodule

//--- logic/pcyn_rob.sv
`include "pcyn_defines.svh"

module pcyn_rob import pcyn_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_reserve_en,
    input  reg_idx_t i_rdst,
    input  rob_tag_t i_lookup_tag [2],
    input  logic     i_cdb_en,
    input  rob_tag_t i_cdb_tag,
    input  word_t    i_cdb_data,
    output rob_tag_t o_reserve_tag,
    output logic     o_stall,
    output logic     o_lookup_rdy [2],
    output word_t    o_lookup_data [2],
    output logic     o_retire_en,
    output reg_idx_t o_retire_rdst,
    output word_t    o_retire_data,
    output rob_tag_t o_retire_tag
);

    localparam int DEPTH = `PCYN_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DEPTH-1:0] done;
    reg_idx_t         rdst_mem [DEPTH];
    word_t            data_mem [DEPTH];
    rob_tag_t         head;
    rob_tag_t         tail;
    logic [CNT_W-1:0] count;
    logic             retire_ok;

    assign o_reserve_tag = tail;
    assign o_stall       = (count == CNT_W'(DEPTH));
    assign retire_ok     = (count != '0) && done[head];

    // Done and data stay valid after retire until the slot is reused
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_lookup_rdy[s]  = done[i_lookup_tag[s]];
            o_lookup_data[s] = data_mem[i_lookup_tag[s]];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            done        <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            o_retire_en <= 1'b0;
        end else begin
            o_retire_en <= retire_ok;
            if (i_cdb_en) begin
                done[i_cdb_tag] <= 1'b1;
            end
            if (i_reserve_en) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (retire_ok) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(i_reserve_en) - CNT_W'(retire_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (i_reserve_en) begin
            rdst_mem[tail] <= i_rdst;
        end
        if (i_cdb_en) begin
            data_mem[i_cdb_tag] <= i_cdb_data;
        end
        if (retire_ok) begin
            o_retire_rdst <= rdst_mem[head];
            o_retire_data <= data_mem[head];
            o_retire_tag  <= head;
        end
    end

endmodule

//--- logic/pcyn_rs.sv
`include "pcyn_defines.svh"

module pcyn_rs import pcyn_pkg::*; #(
    parameter int RS_DEPTH = `PCYN_RS_DEPTH
) (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_reserve_en,
    input  alu_op_e  i_op,
    input  rob_tag_t i_dst_tag,
    input  logic     i_src_rdy [2],
    input  word_t    i_src_data [2],
    input  rob_tag_t i_src_tag [2],
    input  logic     i_cdb_en,
    input  rob_tag_t i_cdb_tag,
    input  word_t    i_cdb_data,
    output logic     o_stall,
    output logic     o_issue_valid,
    output alu_op_e  o_issue_op,
    output word_t    o_issue_src [2],
    output rob_tag_t o_issue_tag
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0] valid;
    logic [IDX_W-1:0]    age [RS_DEPTH];
    logic [1:0]          src_rdy [RS_DEPTH];
    logic [1:0]          wake [RS_DEPTH];
    word_t               src_data [RS_DEPTH][2];
    rob_tag_t            src_tag [RS_DEPTH][2];
    alu_op_e             op [RS_DEPTH];
    rob_tag_t            dst_tag [RS_DEPTH];
    logic [1:0]          res_hit;
    logic [IDX_W-1:0]    free_idx;
    logic [IDX_W-1:0]    issue_idx;
    logic                issue_found;

    assign o_stall = &valid;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            res_hit[s] = !i_src_rdy[s] && i_cdb_en && (i_cdb_tag == i_src_tag[s]);
            for (int i = 0; i < RS_DEPTH; i++) begin
                wake[i][s] = valid[i] && !src_rdy[i][s] && i_cdb_en &&
                             (i_cdb_tag == src_tag[i][s]);
            end
        end
    end

    // Lowest free slot, and the oldest entry with both sources ready
    always_comb begin
        free_idx    = '0;
        issue_idx   = '0;
        issue_found = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (valid[i] && (&src_rdy[i]) && (!issue_found || age[i] > age[issue_idx])) begin
                issue_found = 1'b1;
                issue_idx   = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid         <= '0;
            o_issue_valid <= 1'b0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age[i]     <= '0;
                src_rdy[i] <= 2'b00;
            end
        end else begin
            o_issue_valid <= issue_found;
            for (int i = 0; i < RS_DEPTH; i++) begin
                src_rdy[i] <= src_rdy[i] | wake[i];
                if (i_reserve_en && valid[i]) begin
                    age[i] <= age[i] + 1'b1;
                end
            end
            if (issue_found) begin
                valid[issue_idx] <= 1'b0;
            end
            if (i_reserve_en) begin
                valid[free_idx]   <= 1'b1;
                age[free_idx]     <= '0;
                src_rdy[free_idx] <= {i_src_rdy[1], i_src_rdy[0]} | res_hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                if (wake[i][s]) begin
                    src_data[i][s] <= i_cdb_data;
                end
            end
        end
        if (i_reserve_en) begin
            op[free_idx]      <= i_op;
            dst_tag[free_idx] <= i_dst_tag;
            for (int s = 0; s < 2; s++) begin
                src_tag[free_idx][s]  <= i_src_tag[s];
                src_data[free_idx][s] <= res_hit[s] ? i_cdb_data : i_src_data[s];
            end
        end
        if (issue_found) begin
            o_issue_op     <= op[issue_idx];
            o_issue_tag    <= dst_tag[issue_idx];
            o_issue_src[0] <= src_data[issue_idx][0];
            o_issue_src[1] <= src_data[issue_idx][1];
        end
    end

endmodule

//--- logic/pcyn_ieu.sv
module pcyn_ieu import pcyn_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_valid,
    input  alu_op_e  i_op,
    input  word_t    i_src [2],
    input  rob_tag_t i_tag,
    output logic     o_cdb_en,
    output rob_tag_t o_cdb_tag,
    output word_t    o_cdb_data
);

    word_t      result;
    logic [4:0] shamt;

    assign shamt = i_src[1][4:0];

    always_comb begin
        case (i_op)
            ALU_ADD:  result = i_src[0] + i_src[1];
            ALU_SUB:  result = i_src[0] - i_src[1];
            ALU_AND:  result = i_src[0] & i_src[1];
            ALU_OR:   result = i_src[0] | i_src[1];
            ALU_XOR:  result = i_src[0] ^ i_src[1];
            ALU_SLL:  result = i_src[0] << shamt;
            ALU_SRL:  result = i_src[0] >> shamt;
            ALU_SRA:  result = word_t'($signed(i_src[0]) >>> shamt);
            ALU_SLT:  result = word_t'($signed(i_src[0]) < $signed(i_src[1]));
            ALU_SLTU: result = word_t'(i_src[0] < i_src[1]);
            default:  result = i_src[0] + i_src[1];
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_cdb_tag  <= i_tag;
        o_cdb_data <= result;
    end

endmodule

//--- logic/procyon.sv
module procyon import pcyn_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_ic_valid,
    input  word_t    i_ic_insn,
    output logic     o_ic_en,
    output word_t    o_ic_pc,
    output logic     o_rat_retire_en,
    output reg_idx_t o_rat_retire_rdst,
    output word_t    o_rat_retire_data
);

    logic     fetch_valid;
    word_t    fetch_pc;
    word_t    fetch_insn;
    logic     decode_stall;

    reg_idx_t rat_rsrc [2];
    logic     rat_rdy [2];
    word_t    rat_data [2];
    rob_tag_t rat_tag [2];
    logic     rat_rename_en;
    reg_idx_t rat_rename_rdst;

    logic     rob_reserve_en;
    reg_idx_t rob_rdst;
    rob_tag_t rob_reserve_tag;
    logic     rob_stall;
    rob_tag_t rob_lookup_tag [2];
    logic     rob_lookup_rdy [2];
    word_t    rob_lookup_data [2];

    logic     retire_en;
    reg_idx_t retire_rdst;
    word_t    retire_data;
    rob_tag_t retire_tag;

    logic     rs_reserve_en;
    alu_op_e  rs_op;
    rob_tag_t rs_dst_tag;
    logic     rs_src_rdy [2];
    word_t    rs_src_data [2];
    rob_tag_t rs_src_tag [2];
    logic     rs_stall;

    logic     issue_valid;
    alu_op_e  issue_op;
    word_t    issue_src [2];
    rob_tag_t issue_tag;

    logic     cdb_en;
    rob_tag_t cdb_tag;
    word_t    cdb_data;

    assign o_rat_retire_en   = retire_en;
    assign o_rat_retire_rdst = retire_rdst;
    assign o_rat_retire_data = retire_data;

    pcyn_fetch fetch_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_ic_valid     (i_ic_valid),
        .i_ic_insn      (i_ic_insn),
        .i_decode_stall (decode_stall),
        .o_ic_en        (o_ic_en),
        .o_ic_pc        (o_ic_pc),
        .o_fetch_valid  (fetch_valid),
        .o_fetch_pc     (fetch_pc),
        .o_fetch_insn   (fetch_insn)
    );

    pcyn_decode decode_i (
        .i_fetch_valid     (fetch_valid),
        .i_fetch_pc        (fetch_pc),
        .i_fetch_insn      (fetch_insn),
        .i_rob_stall       (rob_stall),
        .i_rs_stall        (rs_stall),
        .i_rat_rdy         (rat_rdy),
        .i_rat_data        (rat_data),
        .i_rat_tag         (rat_tag),
        .i_rob_lookup_rdy  (rob_lookup_rdy),
        .i_rob_lookup_data (rob_lookup_data),
        .i_rob_reserve_tag (rob_reserve_tag),
        .o_decode_stall    (decode_stall),
        .o_rat_rsrc        (rat_rsrc),
        .o_rat_rename_en   (rat_rename_en),
        .o_rat_rename_rdst (rat_rename_rdst),
        .o_rob_reserve_en  (rob_reserve_en),
        .o_rob_rdst        (rob_rdst),
        .o_rob_lookup_tag  (rob_lookup_tag),
        .o_rs_reserve_en   (rs_reserve_en),
        .o_rs_op           (rs_op),
        .o_rs_dst_tag      (rs_dst_tag),
        .o_rs_src_rdy      (rs_src_rdy),
        .o_rs_src_data     (rs_src_data),
        .o_rs_src_tag      (rs_src_tag)
    );

    pcyn_rat rat_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_rsrc        (rat_rsrc),
        .i_rename_en   (rat_rename_en),
        .i_rename_rdst (rat_rename_rdst),
        .i_rename_tag  (rob_reserve_tag),
        .i_retire_en   (retire_en),
        .i_retire_rdst (retire_rdst),
        .i_retire_data (retire_data),
        .i_retire_tag  (retire_tag),
        .o_rdy         (rat_rdy),
        .o_data        (rat_data),
        .o_tag         (rat_tag)
    );

    pcyn_rob rob_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_reserve_en  (rob_reserve_en),
        .i_rdst        (rob_rdst),
        .i_lookup_tag  (rob_lookup_tag),
        .i_cdb_en      (cdb_en),
        .i_cdb_tag     (cdb_tag),
        .i_cdb_data    (cdb_data),
        .o_reserve_tag (rob_reserve_tag),
        .o_stall       (rob_stall),
        .o_lookup_rdy  (rob_lookup_rdy),
        .o_lookup_data (rob_lookup_data),
        .o_retire_en   (retire_en),
        .o_retire_rdst (retire_rdst),
        .o_retire_data (retire_data),
        .o_retire_tag  (retire_tag)
    );

    pcyn_rs rs_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_reserve_en  (rs_reserve_en),
        .i_op          (rs_op),
        .i_dst_tag     (rs_dst_tag),
        .i_src_rdy     (rs_src_rdy),
        .i_src_data    (rs_src_data),
        .i_src_tag     (rs_src_tag),
        .i_cdb_en      (cdb_en),
        .i_cdb_tag     (cdb_tag),
        .i_cdb_data    (cdb_data),
        .o_stall       (rs_stall),
        .o_issue_valid (issue_valid),
        .o_issue_op    (issue_op),
        .o_issue_src   (issue_src),
        .o_issue_tag   (issue_tag)
    );

    pcyn_ieu ieu_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (issue_valid),
        .i_op       (issue_op),
        .i_src      (issue_src),
        .i_tag      (issue_tag),
        .o_cdb_en   (cdb_en),
        .o_cdb_tag  (cdb_tag),
        .o_cdb_data (cdb_data)
    );

endmodule

//--- sim/procyon_assertions.sv
`include "pcyn_defines.svh"

module procyon_assertions import pcyn_pkg::*; #(
    parameter int CNT_W = $clog2(`PCYN_ROB_DEPTH + 1)
) (
    input logic             clk,
    input logic             i_rst_n,
    input logic             i_reserve_en,
    input logic [CNT_W-1:0] i_count,
    input rob_tag_t         i_head,
    input rob_tag_t         i_tail,
    input logic             i_stall,
    input logic             i_retire_en,
    input rob_tag_t         i_retire_tag
);

    logic [CNT_W-1:0] occupied;
    rob_tag_t         next_tag;

    // Entries reserved and not yet seen on the retire outputs
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            occupied <= '0;
            next_tag <= '0;
        end else begin
            occupied <= occupied + CNT_W'(i_reserve_en) - CNT_W'(i_retire_en);
            if (i_retire_en) begin
                next_tag <= i_retire_tag + 1'b1;
            end
        end
    end

    retire_not_empty: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_retire_en |-> occupied != '0
    ) else $error("ROB retired an entry while empty");

    // Full means the pointers meet with entries present
    stall_when_full: assert property (
        @(posedge clk) disable iff (!i_rst_n)
            i_stall == ((i_count != '0) && (i_head == i_tail))
    ) else $error("ROB stall disagrees with its entry count");

    // Tags retire in allocation order starting from tag 0
    retire_from_head: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_retire_en |-> i_retire_tag == next_tag
    ) else $error("ROB retired a tag other than its head");

endmodule

bind pcyn_rob procyon_assertions rob_checks_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_reserve_en (i_reserve_en),
    .i_count      (count),
    .i_head       (head),
    .i_tail       (tail),
    .i_stall      (o_stall),
    .i_retire_en  (o_retire_en),
    .i_retire_tag (o_retire_tag)
);

//--- sim/procyon_tb.sv
`include "pcyn_defines.svh"

module procyon_tb import pcyn_pkg::*; ();

    localparam int MAX_CASES  = 64;
    localparam int WAIT_LIMIT = 200;
    localparam int STALL_TEST = 5;
    localparam int TAIL_NOPS  = 4;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     ic_valid = 1'b0;
    word_t    ic_insn = `PCYN_NOP;
    logic     ic_en;
    word_t    ic_pc;
    logic     retire_en;
    reg_idx_t retire_rdst;
    word_t    retire_data;

    // Four words per case: test, instruction, destination, value
    word_t       case_words [4*MAX_CASES];
    int          num_cases;
    logic [31:0] lcg_state = 32'hb8fc;
    word_t       exp_pc;
    int          checks;
    int          errors;
    int          test_errors;

    always #5 clk = ~clk;

    procyon dut_i (
        .clk               (clk),
        .i_rst_n           (rst_n),
        .i_ic_valid        (ic_valid),
        .i_ic_insn         (ic_insn),
        .o_ic_en           (ic_en),
        .o_ic_pc           (ic_pc),
        .o_rat_retire_en   (retire_en),
        .o_rat_retire_rdst (retire_rdst),
        .o_rat_retire_data (retire_data)
    );

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Instruction memory, one program from address 0 and NOPs past its end
    always @(posedge clk) begin
        int idx;
        #1;
        idx       = int'(ic_pc >> 2);
        lcg_state = next_random(lcg_state);
        if (idx < num_cases) begin
            ic_insn  = case_words[4*idx+1];
            // Random fetch back-pressure only inside the stall test
            ic_valid = (case_words[4*idx] == STALL_TEST) ? lcg_state[16] : 1'b1;
        end else begin
            ic_insn  = `PCYN_NOP;
            ic_valid = 1'b1;
        end
    end

    // Fetch address advances by one word per transfer and holds otherwise
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_pc = `PCYN_RESET_PC;
            check_equal("instruction port enable in reset", 32'(ic_en), 32'd0);
            check_equal("retire enable in reset", 32'(retire_en), 32'd0);
        end else begin
            check_equal("fetch address", ic_pc, exp_pc);
            if (ic_en && ic_valid) begin
                exp_pc = exp_pc + 32'd4;
            end
        end
    end

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            test_errors++;
            $display("FAIL %0t: %s is %08h, expected %08h", $time, what, got, expected);
        end
    endtask

    task automatic wait_retire(output logic seen);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!retire_en && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        seen = retire_en;
    endtask

    initial begin
        logic        seen;
        logic        timed_out;
        int          tests_done;
        int          tests_bad;
        int          retired;
        logic [31:0] exp_rdst;
        rst_n       = 1'b0;
        seen        = 1'b0;
        timed_out   = 1'b0;
        tests_done  = 0;
        tests_bad   = 0;
        retired     = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        num_cases   = 0;
        for (int i = 0; i < 4*MAX_CASES; i++) begin
            case_words[i] = '0;
        end
        $readmemh("sim/procyon_cases.txt", case_words);
        while (num_cases < MAX_CASES && case_words[4*num_cases] != '0) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("No test cases were read from sim/procyon_cases.txt");
            errors++;
        end

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Retire order equals program order, so retirement k belongs to case k
        for (int k = 0; k < num_cases && !timed_out; k++) begin
            wait_retire(seen);
            if (!seen) begin
                $display("Timeout: case %0d of test %0d did not retire within %0d cycles",
                         k, case_words[4*k], WAIT_LIMIT);
                timed_out = 1'b1;
            end else begin
                retired++;
                exp_rdst = case_words[4*k+2];
                check_equal($sformatf("test %0d case %0d destination", case_words[4*k], k),
                            32'(retire_rdst), exp_rdst);
                // Destination 0 writes nothing, so its value is meaningless
                if (exp_rdst != '0) begin
                    check_equal($sformatf("test %0d case %0d value", case_words[4*k], k),
                                retire_data, case_words[4*k+3]);
                end
                if (k == num_cases - 1 || case_words[4*k+4] != case_words[4*k]) begin
                    $display("test %0d done: %0d retirements, %0d mismatches",
                             case_words[4*k], retired, test_errors);
                    tests_done++;
                    if (test_errors != 0) begin
                        tests_bad++;
                    end
                    retired     = 0;
                    test_errors = 0;
                end
            end
        end

        // Past the program only NOPs may retire, no repeated entries
        for (int n = 0; n < TAIL_NOPS && !timed_out; n++) begin
            wait_retire(seen);
            if (!seen) begin
                $display("Timeout: no retirement after the program within %0d cycles",
                         WAIT_LIMIT);
                timed_out = 1'b1;
            end else begin
                check_equal("NOP destination after the program", 32'(retire_rdst), 32'd0);
            end
        end
        if (!timed_out) begin
            $display("NOP tail done: %0d retirements, %0d mismatches", TAIL_NOPS, test_errors);
        end

        $display("%0d tests, %0d with mismatches, %0d checks, %0d mismatches",
                 tests_done, tests_bad, checks, errors);
        if (timed_out || errors != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule

//--- sim/procyon_cases.txt
// test insn rdst value, all hex, one line per retirement in program order
// 1 imm and LUI, 2 chain, 3 reg ops, 4 x0 and unsupported, 5 repeat of 2, 6 chain and burst
1 00500093 01 00000005 // addi x1, x0, 5
1 ffd00113 02 fffffffd // addi x2, x0, -3
1 123451b7 03 12345000 // lui x3, 0x12345
1 0f004213 04 000000f0 // xori x4, x0, 0xf0
1 7ff06293 05 000007ff // ori x5, x0, 0x7ff
2 00a00313 06 0000000a // addi x6, x0, 10
2 01430313 06 0000001e // addi x6, x6, 20
2 006303b3 07 0000003c // add x7, x6, x6
2 40638433 08 0000001e // sub x8, x7, x6
2 007474b3 09 0000001c // and x9, x8, x7
3 40208533 0a 00000008 // sub x10, x1, x2
3 001195b3 0b 468a0000 // sll x11, x3, x1
3 40115633 0c ffffffff // sra x12, x2, x1
3 001156b3 0d 07ffffff // srl x13, x2, x1
3 00112733 0e 00000001 // slt x14, x2, x1
3 001137b3 0f 00000000 // sltu x15, x2, x1
4 00500013 00 00000000 // addi x0, x0, 5
4 00112023 00 00000000 // sw x1, 0(x2)
4 00000833 10 00000000 // add x16, x0, x0
5 00a00313 06 0000000a // addi x6, x0, 10
5 01430313 06 0000001e // addi x6, x6, 20
5 006303b3 07 0000003c // add x7, x6, x6
5 40638433 08 0000001e // sub x8, x7, x6
5 007474b3 09 0000001c // and x9, x8, x7
6 06400893 11 00000064 // addi x17, x0, 100
6 00188893 11 00000065 // addi x17, x17, 1
6 00188893 11 00000066
6 00188893 11 00000067
6 00188893 11 00000068
6 00188893 11 00000069
6 00188893 11 0000006a
6 00188893 11 0000006b
6 01200913 12 00000012 // addi x18, x0, 18
6 01300993 13 00000013
6 01400a13 14 00000014
6 01500a93 15 00000015
6 01600b13 16 00000016
6 01700b93 17 00000017
6 01800c13 18 00000018
6 01900c93 19 00000019 // addi x25, x0, 25

//--- all.f
+incdir+logic
logic/pcyn_pkg.sv
logic/pcyn_fetch.sv
logic/pcyn_decode.sv
logic/pcyn_rat.sv
logic/pcyn_rob.sv
logic/pcyn_rs.sv
logic/pcyn_ieu.sv
logic/procyon.sv
sim/procyon_assertions.sv
sim/procyon_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = procyon_tb
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
